// File: hw/can_cfg_pkg.sv
// CAN transmit controller configuration definitions
// Host register map, register bit positions and bus timing fields
`default_nettype none

package can_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Host register map
  ////////////////////////////////////////////////////////////////////////////

  // Register data width, one byte per address
  localparam int REG_W = 8;

  // BASIC mode addresses
  localparam logic [REG_W-1:0] ADDR_MODE   = 8'd0;
  localparam logic [REG_W-1:0] ADDR_CMD    = 8'd1;
  localparam logic [REG_W-1:0] ADDR_STATUS = 8'd2;
  localparam logic [REG_W-1:0] ADDR_IRQ    = 8'd3;
  localparam logic [REG_W-1:0] ADDR_IRQ_EN = 8'd4;
  // Address 5 stays unused in this reduced map
  localparam logic [REG_W-1:0] ADDR_BTR0   = 8'd6;
  localparam logic [REG_W-1:0] ADDR_BTR1   = 8'd7;

  // Bit positions inside the registers
  localparam int MODE_RESET_BIT = 0;
  localparam int CMD_TX_REQ_BIT = 0;
  localparam int STAT_TBS_BIT   = 2;
  localparam int STAT_TCS_BIT   = 3;
  localparam int STAT_TX_BIT    = 5;
  localparam int IRQ_TX_BIT     = 1;

  ////////////////////////////////////////////////////////////////////////////
  // Bus timing
  ////////////////////////////////////////////////////////////////////////////

  // BTR0[5:0] is the prescaler, BTR1[3:0] tseg1 and BTR1[6:4] tseg2
  typedef struct packed {
    logic [5:0] baud_presc;
    logic [3:0] tseg1;
    logic [2:0] tseg2;
  } can_timing_t;

endpackage

`default_nettype wire

// File: hw/can_frame_pkg.sv
// CAN standard frame definitions
// Transmit buffer layout, field lengths and transmitter states
`default_nettype none

package can_frame_pkg;

  // Buffer holds two header bytes followed by the data bytes
  localparam int FRAME_BYTES    = 10;
  localparam int MAX_DATA_BYTES = 8;

  // Five equal bits force a complement bit
  localparam int STUFF_LEN = 5;
  // Recessive end-of-frame field, never stuffed
  localparam int EOF_BITS  = 7;
  localparam int ID_BITS   = 11;

  // SOF, identifier, RTR, IDE, r0 and the 4-bit DLC
  localparam int HDR_BITS = 1 + ID_BITS + 3 + 4;

  // Byte 0 sits in the top bits of the vector
  //   byte 0    id[10:3]
  //   byte 1    id[2:0] in 7..5, rtr in 4, dlc in 3..0
  //   byte 2..9 data, first byte sent first
  typedef struct packed {
    logic [0:FRAME_BYTES-1][7:0] bytes;
  } can_frame_t;

  // Transmitter phases
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_HEADER,
    TX_DATA,
    TX_EOF
  } tx_state_e;

endpackage

`default_nettype wire

// File: hw/can_regs.sv
// CAN host register file
// Mode, command, status, interrupt and bus timing registers with registered read data
`default_nettype none

module can_regs (
  input  logic                          clk_i,
  input  logic                          rst,
  input  logic                          reg_we_i,
  input  logic                          reg_re_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_waddr_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_raddr_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_data_i,
  output logic [can_cfg_pkg::REG_W-1:0] reg_data_o,
  input  logic                          tbs_i,
  input  logic                          busy_i,
  input  logic                          done_i,
  output logic                          reset_mode_o,
  output logic                          tx_req_o,
  output can_cfg_pkg::can_timing_t      timing_o,
  output logic                          irq_on_o
);
  import can_cfg_pkg::*;

  logic             reset_mode;
  logic             irq_flag;
  logic             irq_en;
  logic             tcs;
  can_timing_t      timing_q;
  logic             wr_mode;
  logic             wr_cmd;
  logic             wr_irq_en;
  logic             wr_btr0;
  logic             wr_btr1;
  logic             rd_irq;
  logic [REG_W-1:0] rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  assign wr_mode   = reg_we_i && (reg_waddr_i == ADDR_MODE);
  assign wr_cmd    = reg_we_i && (reg_waddr_i == ADDR_CMD);
  assign wr_irq_en = reg_we_i && (reg_waddr_i == ADDR_IRQ_EN);
  // Bus timing is frozen once the node leaves reset mode
  assign wr_btr0   = reg_we_i && (reg_waddr_i == ADDR_BTR0) && reset_mode;
  assign wr_btr1   = reg_we_i && (reg_waddr_i == ADDR_BTR1) && reset_mode;
  // Reading the interrupt register acknowledges it
  assign rd_irq    = reg_re_i && (reg_raddr_i == ADDR_IRQ);

  // Request only reaches the core when running and the buffer is free
  assign tx_req_o = wr_cmd && reg_data_i[CMD_TX_REQ_BIT] && !reset_mode && tbs_i;

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      reset_mode <= 1'b1;
      irq_en     <= 1'b0;
      timing_q   <= '0;
    end
    else
    begin
      if (wr_mode)
        reset_mode <= reg_data_i[MODE_RESET_BIT];
      if (wr_irq_en)
        irq_en <= reg_data_i[IRQ_TX_BIT];
      if (wr_btr0)
        timing_q.baud_presc <= reg_data_i[5:0];
      if (wr_btr1)
      begin
        timing_q.tseg1 <= reg_data_i[3:0];
        timing_q.tseg2 <= reg_data_i[6:4];
      end
    end
  end

  // TCS starts set since nothing is outstanding after reset
  // Completion wins over a same-cycle acknowledge of the flag
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      tcs      <= 1'b1;
      irq_flag <= 1'b0;
    end
    else
    begin
      if (tx_req_o)
        tcs <= 1'b0;
      else if (done_i)
        tcs <= 1'b1;
      if (done_i)
        irq_flag <= 1'b1;
      else if (rd_irq)
        irq_flag <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_data = '0;
    case (reg_raddr_i)
      ADDR_MODE:   rd_data[MODE_RESET_BIT] = reset_mode;
      ADDR_STATUS:
      begin
        rd_data[STAT_TBS_BIT] = tbs_i;
        rd_data[STAT_TCS_BIT] = tcs;
        rd_data[STAT_TX_BIT]  = busy_i;
      end
      ADDR_IRQ:    rd_data[IRQ_TX_BIT] = irq_flag;
      ADDR_IRQ_EN: rd_data[IRQ_TX_BIT] = irq_en;
      ADDR_BTR0:   rd_data = {2'b00, timing_q.baud_presc};
      ADDR_BTR1:   rd_data = {1'b0, timing_q.tseg2, timing_q.tseg1};
      // Command register and unmapped addresses read as zero
      default:     rd_data = '0;
    endcase
  end

  // Read data holds between strobes
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      reg_data_o <= '0;
    else if (reg_re_i)
      reg_data_o <= rd_data;
  end

  assign reset_mode_o = reset_mode;
  assign timing_o     = timing_q;
  // Active low interrupt line
  assign irq_on_o     = ~(irq_flag & irq_en);

endmodule

`default_nettype wire

// File: hw/can_tx_buffer.sv
// CAN transmit buffer
// Ten frame bytes, locked from the request until the frame completes
`default_nettype none

module can_tx_buffer (
  input  logic                      clk_i,
  input  logic                      rst,
  input  logic                      tx_we_i,
  input  logic [3:0]                tx_addr_i,
  input  logic [7:0]                tx_data_i,
  input  logic                      reset_mode_i,
  input  logic                      tx_req_i,
  input  logic                      done_i,
  output can_frame_pkg::can_frame_t frame_o,
  output logic                      tbs_o
);
  import can_frame_pkg::*;

  can_frame_t frame_q;
  logic       locked;
  logic       wr_ok;

  // Host writes land only in a released buffer and inside the frame
  assign wr_ok = tx_we_i && !locked && (tx_addr_i < FRAME_BYTES);

  // Frame bytes
  always_ff @(posedge clk_i)
  begin
    if (wr_ok)
      frame_q.bytes[tx_addr_i] <= tx_data_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Lock control
  ////////////////////////////////////////////////////////////////////////////

  // Locked from the cycle after the request
  // Released after completion, or when reset mode aborts the frame
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
      locked <= 1'b0;
    else if (done_i || reset_mode_i)
      locked <= 1'b0;
    else if (tx_req_i)
      locked <= 1'b1;
  end

  // Transmitter reads the stored bytes directly
  assign frame_o = frame_q;
  // Buffer status, high when released
  assign tbs_o   = ~locked;

endmodule

`default_nettype wire

// File: hw/can_bit_timing.sv
// CAN bit timing unit
// Prescaler and time quantum counter producing one tx strobe per bit
`default_nettype none

module can_bit_timing (
  input  logic                     clk_i,
  input  logic                     rst,
  input  logic                     reset_mode_i,
  input  can_cfg_pkg::can_timing_t timing_i,
  output logic                     tx_point_o
);
  import can_cfg_pkg::*;

  logic [6:0] clk_cnt;
  logic [6:0] clk_last;
  logic [4:0] q_cnt;
  logic [4:0] q_last;
  logic       q_tick;

  // Quantum is 2 * (presc + 1) clocks
  assign clk_last = {timing_i.baud_presc, 1'b1};
  assign q_tick   = (clk_cnt == clk_last);

  // Bit is sync quantum plus tseg1 + 1 plus tseg2 + 1
  assign q_last = 5'd2 + {1'b0, timing_i.tseg1} + {2'b00, timing_i.tseg2};

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      clk_cnt    <= '0;
      q_cnt      <= '0;
      tx_point_o <= 1'b0;
    end
    else if (reset_mode_i)
    begin
      // Held at the start of a bit while configuring
      clk_cnt    <= '0;
      q_cnt      <= '0;
      tx_point_o <= 1'b0;
    end
    else
    begin
      tx_point_o <= 1'b0;
      if (q_tick)
      begin
        clk_cnt <= '0;
        if (q_cnt == q_last)
        begin
          // Wrap, next bit begins
          q_cnt      <= '0;
          tx_point_o <= 1'b1;
        end
        else
        begin
          q_cnt <= q_cnt + 5'd1;
        end
      end
      else
      begin
        clk_cnt <= clk_cnt + 7'd1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/can_bit_tx.sv
// CAN bit transmitter
// Serializes a BASIC mode standard frame with bit stuffing and a recessive EOF
`default_nettype none

module can_bit_tx (
  input  logic                      clk_i,
  input  logic                      rst,
  input  logic                      reset_mode_i,
  input  logic                      tx_point_i,
  input  logic                      tx_req_i,
  input  can_frame_pkg::can_frame_t frame_i,
  output logic                      tx_o,
  output logic                      busy_o,
  output logic                      done_o
);
  import can_frame_pkg::*;

  tx_state_e           state;
  logic                pending;
  logic [6:0]          bit_cnt;
  logic [2:0]          stuff_cnt;
  logic                last_bit;
  logic [ID_BITS-1:0]  id;
  logic                rtr;
  logic [3:0]          dlc;
  logic [3:0]          data_len;
  logic [HDR_BITS-1:0] hdr;
  logic [4:0]          hdr_idx;
  logic [6:0]          dat_idx;
  logic                hdr_done;
  logic                data_done;
  logic                stuff_now;
  logic                more;
  logic                field_bit;
  logic [2:0]          run_next;

  ////////////////////////////////////////////////////////////////////////////
  // Frame fields
  ////////////////////////////////////////////////////////////////////////////

  assign id  = {frame_i.bytes[0], frame_i.bytes[1][7:5]};
  assign rtr = frame_i.bytes[1][4];
  assign dlc = frame_i.bytes[1][3:0];
  // Remote frames carry no data, DLC above 8 still sends 8 bytes
  assign data_len = rtr ? 4'd0 : (dlc > MAX_DATA_BYTES) ? 4'(MAX_DATA_BYTES) : dlc;

  // IDE and r0 both dominant
  assign hdr     = {1'b0, id, rtr, 2'b00, dlc};
  assign hdr_idx = 5'(HDR_BITS - 1) - bit_cnt[4:0];
  // Header to data hand-over sends data bit 0
  assign dat_idx = (state == TX_DATA) ? bit_cnt : 7'd0;

  assign hdr_done  = (bit_cnt == 7'(HDR_BITS));
  assign data_done = (bit_cnt == {data_len, 3'b000});
  assign stuff_now = (stuff_cnt == 3'(STUFF_LEN));
  // Another unstuffed bit is still due before EOF
  assign more = (state == TX_HEADER) ? (!hdr_done || data_len != 4'd0) : !data_done;

  // Data bytes start after the two header bytes, MSB first
  always_comb
  begin
    if (state == TX_HEADER && !hdr_done)
      field_bit = hdr[hdr_idx];
    else
      field_bit = frame_i.bytes[(FRAME_BYTES - MAX_DATA_BYTES) + dat_idx[5:3]][~dat_idx[2:0]];
  end

  // Length of the equal-bit run after this bit
  assign run_next = (field_bit == last_bit) ? stuff_cnt + 3'd1 : 3'd1;

  assign busy_o = (state != TX_IDLE);
  // Strobe that ends the last EOF bit
  assign done_o = tx_point_i && (state == TX_EOF) && (bit_cnt == 7'(EOF_BITS));

  ////////////////////////////////////////////////////////////////////////////
  // Transmit FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst || reset_mode_i)
    begin
      // Reset mode drops any frame in flight and leaves the bus recessive
      state     <= TX_IDLE;
      pending   <= 1'b0;
      tx_o      <= 1'b1;
      bit_cnt   <= '0;
      stuff_cnt <= '0;
      last_bit  <= 1'b1;
    end
    else
    begin
      if (tx_req_i)
        pending <= 1'b1;
      if (tx_point_i)
      begin
        case (state)
          TX_IDLE:
            if (pending)
            begin
              // Start of frame, first bit of a new run
              state     <= TX_HEADER;
              pending   <= 1'b0;
              tx_o      <= 1'b0;
              last_bit  <= 1'b0;
              stuff_cnt <= 3'd1;
              bit_cnt   <= 7'd1;
            end
          TX_HEADER, TX_DATA:
            if (stuff_now)
            begin
              // Complement bit opens a new run, field position unchanged
              tx_o      <= ~last_bit;
              last_bit  <= ~last_bit;
              stuff_cnt <= 3'd1;
            end
            else if (more)
            begin
              tx_o      <= field_bit;
              last_bit  <= field_bit;
              stuff_cnt <= run_next;
              if (state == TX_HEADER && hdr_done)
              begin
                state   <= TX_DATA;
                bit_cnt <= 7'd1;
              end
              else
                bit_cnt <= bit_cnt + 7'd1;
            end
            else
            begin
              // First EOF bit
              state   <= TX_EOF;
              tx_o    <= 1'b1;
              bit_cnt <= 7'd1;
            end
          TX_EOF:
            if (bit_cnt == 7'(EOF_BITS))
              state <= TX_IDLE;
            else
              bit_cnt <= bit_cnt + 7'd1;
          default:
            state <= TX_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/can_tx_top.sv
// CAN transmit controller top level
// Register block, transmit buffer, bit timing and bit transmitter
`default_nettype none

module can_tx_top (
  input  logic                          clk_i,
  input  logic                          rst,
  // Host register port
  input  logic                          reg_we_i,
  input  logic                          reg_re_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_waddr_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_raddr_i,
  input  logic [can_cfg_pkg::REG_W-1:0] reg_data_i,
  output logic [can_cfg_pkg::REG_W-1:0] reg_data_o,
  // Transmit buffer port
  input  logic                          tx_we_i,
  input  logic [3:0]                    tx_addr_i,
  input  logic [7:0]                    tx_data_i,
  // CAN side
  output logic                          tx_o,
  output logic                          irq_on
);
  import can_cfg_pkg::*;
  import can_frame_pkg::*;

  logic        reset_mode;
  logic        tx_req;
  logic        tbs;
  logic        busy;
  logic        done;
  logic        tx_point;
  can_timing_t timing;
  can_frame_t  frame;

  can_regs i_can_regs (
    .clk_i        (clk_i),
    .rst          (rst),
    .reg_we_i     (reg_we_i),
    .reg_re_i     (reg_re_i),
    .reg_waddr_i  (reg_waddr_i),
    .reg_raddr_i  (reg_raddr_i),
    .reg_data_i   (reg_data_i),
    .reg_data_o   (reg_data_o),
    .tbs_i        (tbs),
    .busy_i       (busy),
    .done_i       (done),
    .reset_mode_o (reset_mode),
    .tx_req_o     (tx_req),
    .timing_o     (timing),
    .irq_on_o     (irq_on)
  );

  can_tx_buffer i_can_tx_buffer (
    .clk_i        (clk_i),
    .rst          (rst),
    .tx_we_i      (tx_we_i),
    .tx_addr_i    (tx_addr_i),
    .tx_data_i    (tx_data_i),
    .reset_mode_i (reset_mode),
    .tx_req_i     (tx_req),
    .done_i       (done),
    .frame_o      (frame),
    .tbs_o        (tbs)
  );

  can_bit_timing i_can_bit_timing (
    .clk_i        (clk_i),
    .rst          (rst),
    .reset_mode_i (reset_mode),
    .timing_i     (timing),
    .tx_point_o   (tx_point)
  );

  can_bit_tx i_can_bit_tx (
    .clk_i        (clk_i),
    .rst          (rst),
    .reset_mode_i (reset_mode),
    .tx_point_i   (tx_point),
    .tx_req_i     (tx_req),
    .frame_i      (frame),
    .tx_o         (tx_o),
    .busy_o       (busy),
    .done_o       (done)
  );

endmodule

`default_nettype wire

// File: sim/can_tx_checker.sv
// CAN transmit checker
// Bound assertions on the line level, bit stuffing and buffer lock
`default_nettype none

module can_tx_checker (
  input  logic                     clk_i,
  input  logic                     rst,
  input  logic                     tx_i,
  input  logic                     busy_i,
  input  logic                     tbs_i,
  input  logic                     tx_point_i,
  input  can_frame_pkg::tx_state_e state_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import can_frame_pkg::*;

  // Failed assertions, watched by the testbench
  int         fail_cnt = 0;
  logic [3:0] run_len;
  logic       prev_bit;

  // Run of equal bits in the stuffed fields, updated as each bit ends
  always_ff @(posedge clk_i or posedge rst)
  begin
    if (rst)
    begin
      run_len  <= '0;
      prev_bit <= 1'b1;
    end
    else if (tx_point_i)
    begin
      if (state_i == TX_HEADER || state_i == TX_DATA)
      begin
        if (run_len != 4'd0 && tx_i == prev_bit)
          run_len <= run_len + 4'd1;
        else
          run_len <= 4'd1;
        prev_bit <= tx_i;
      end
      else
        run_len <= '0;
    end
  end

  // Idle bus stays recessive
  idle_recessive: assert property (@(posedge clk_i) disable iff (rst) !busy_i |-> tx_i)
    else begin $error("tx low while idle"); fail_cnt = fail_cnt + 1; end

  stuff_rule: assert property (@(posedge clk_i) disable iff (rst) run_len <= 4'(STUFF_LEN))
    else begin $error("six equal bits in stuffed stream"); fail_cnt = fail_cnt + 1; end

  // Buffer stays locked for the whole frame
  locked_busy: assert property (@(posedge clk_i) disable iff (rst) busy_i |-> !tbs_i)
    else begin $error("buffer released during frame"); fail_cnt = fail_cnt + 1; end

endmodule

`default_nettype wire

// File: sim/can_tx_tb.sv
// CAN transmit controller testbench
// Random standard frames checked bit by bit against a stuffing model
`default_nettype none

module can_tx_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import can_cfg_pkg::*;
  import can_frame_pkg::*;

  localparam int CLK_PERIOD     = 40;
  localparam int PRESC          = 1;
  localparam int TSEG1          = 4;
  localparam int TSEG2          = 2;
  // Quantum is 2 * (presc + 1) clocks, bit is 3 + tseg1 + tseg2 quanta
  localparam int BIT_CLKS       = 2 * (PRESC + 1) * (3 + TSEG1 + TSEG2);
  localparam int NUM_FRAMES     = 12;
  // Header, 8 data bytes, worst case stuffing and EOF
  localparam int MAX_FRAME_BITS = 120;
  localparam int WATCHDOG_NS    = NUM_FRAMES * MAX_FRAME_BITS * BIT_CLKS * CLK_PERIOD + 200000;

  logic       clk_i = 1'b0;
  logic       rst;
  logic       reg_we_i;
  logic       reg_re_i;
  logic [7:0] reg_waddr_i;
  logic [7:0] reg_raddr_i;
  logic [7:0] reg_data_i;
  logic [7:0] reg_data_o;
  logic       tx_we_i;
  logic [3:0] tx_addr_i;
  logic [7:0] tx_data_i;
  logic       tx_o;
  logic       irq_on;

  // Bytes written before the request, and the expected line bits
  logic [7:0] frame_bytes [FRAME_BYTES];
  bit         exp_bits [$];

  can_tx_top uut (
    .clk_i       (clk_i),
    .rst         (rst),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_waddr_i (reg_waddr_i),
    .reg_raddr_i (reg_raddr_i),
    .reg_data_i  (reg_data_i),
    .reg_data_o  (reg_data_o),
    .tx_we_i     (tx_we_i),
    .tx_addr_i   (tx_addr_i),
    .tx_data_i   (tx_data_i),
    .tx_o        (tx_o),
    .irq_on      (irq_on)
  );

  bind can_tx_top can_tx_checker u_checker (
    .clk_i      (clk_i),
    .rst        (rst),
    .tx_i       (tx_o),
    .busy_i     (busy),
    .tbs_i      (tbs),
    .tx_point_i (tx_point),
    .state_i    (i_can_bit_tx.state)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp)
      abort_run($sformatf("FAIL %s exp=0x%0h got=0x%0h", name, exp, got));
  endtask

  // Watchdog sized from the frame count and worst case frame length
  initial
  begin
    #(WATCHDOG_NS);
    abort_run("Timeout: simulation exceeded the expected run time");
  end

  always @(negedge clk_i)
  begin
    if (uut.u_checker.fail_cnt != 0)
      abort_run("A bound checker assertion failed");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Host access, each task starts and ends just after a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
    reg_we_i    = 1'b1;
    reg_waddr_i = addr;
    reg_data_i  = data;
    @(negedge clk_i);
    reg_we_i    = 1'b0;
  endtask

  // Read data registers on the rising edge in between
  task automatic read_reg(input logic [7:0] addr, output logic [7:0] data);
    reg_re_i    = 1'b1;
    reg_raddr_i = addr;
    @(negedge clk_i);
    reg_re_i    = 1'b0;
    data        = reg_data_o;
  endtask

  task automatic write_buf(input logic [3:0] addr, input logic [7:0] data);
    tx_we_i   = 1'b1;
    tx_addr_i = addr;
    tx_data_i = data;
    @(negedge clk_i);
    tx_we_i   = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Frame model
  ////////////////////////////////////////////////////////////////////////////

  task automatic build_expected();
    bit         fields [$];
    logic [10:0] id;
    logic       rtr;
    logic [3:0] dlc;
    int         nbytes;
    int         run;
    bit         last;
    id  = {frame_bytes[0], frame_bytes[1][7:5]};
    rtr = frame_bytes[1][4];
    dlc = frame_bytes[1][3:0];
    // SOF, ID, RTR, IDE, r0, DLC
    fields.push_back(1'b0);
    for (int i = 10; i >= 0; i--)
      fields.push_back(id[i]);
    fields.push_back(rtr);
    fields.push_back(1'b0);
    fields.push_back(1'b0);
    for (int i = 3; i >= 0; i--)
      fields.push_back(dlc[i]);
    // Remote frame carries no data, DLC above 8 caps at 8 bytes
    nbytes = rtr ? 0 : ((dlc > 8) ? 8 : int'(dlc));
    for (int b = 0; b < nbytes; b++)
      for (int i = 7; i >= 0; i--)
        fields.push_back(frame_bytes[2 + b][i]);
    // Complement bit after five equal bits, stuff bit starts a new run
    exp_bits.delete();
    run  = 0;
    last = 1'b1;
    foreach (fields[k])
    begin
      exp_bits.push_back(fields[k]);
      run  = (run != 0 && fields[k] == last) ? run + 1 : 1;
      last = fields[k];
      if (run == STUFF_LEN)
      begin
        exp_bits.push_back(~last);
        last = ~last;
        run  = 1;
      end
    end
    repeat (EOF_BITS) exp_bits.push_back(1'b1);
  endtask

  // Samples mid bit from the SOF edge, optionally hitting the locked buffer
  task automatic check_frame(input bit corrupt);
    int wait_cyc;
    int cyc;
    int next_sample;
    int idx;
    wait_cyc = 0;
    while (tx_o !== 1'b0)
    begin
      @(negedge clk_i);
      wait_cyc++;
      if (wait_cyc > 2 * BIT_CLKS + 4)
        abort_run("No start-of-frame edge after the tx request");
    end
    cyc         = 0;
    idx         = 0;
    next_sample = BIT_CLKS / 2;
    while (idx < exp_bits.size())
    begin
      @(negedge clk_i);
      cyc++;
      if (corrupt && (cyc % 29 == 3))
      begin
        tx_we_i   = 1'b1;
        tx_addr_i = 4'($urandom_range(0, 9));
        tx_data_i = 8'($urandom);
      end
      else
        tx_we_i = 1'b0;
      if (cyc == next_sample)
      begin
        check_value($sformatf("tx_o bit %0d", idx), 32'(exp_bits[idx]), 32'(tx_o));
        idx++;
        next_sample += BIT_CLKS;
      end
    end
    tx_we_i = 1'b0;
  endtask

  // Polls status until TCS shows completion
  task automatic wait_done();
    logic [7:0] d;
    int         polls;
    d     = '0;
    polls = 0;
    while (!d[STAT_TCS_BIT])
    begin
      read_reg(ADDR_STATUS, d);
      polls++;
      if (polls > 2 * BIT_CLKS)
        abort_run("Frame did not complete, TCS never set");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [7:0]  d;
    logic [10:0] id;
    logic        rtr;
    logic [3:0]  dlc;
    rst         = 1'b1;
    reg_we_i    = 1'b0;
    reg_re_i    = 1'b0;
    reg_waddr_i = '0;
    reg_raddr_i = '0;
    reg_data_i  = '0;
    tx_we_i     = 1'b0;
    tx_addr_i   = '0;
    tx_data_i   = '0;
    void'($urandom(32'h9728));
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst = 1'b0;

    // Reset values
    check_value("tx_o", 1, tx_o);
    check_value("irq_on", 1, irq_on);
    check_value("reg_data_o", 0, reg_data_o);
    read_reg(ADDR_MODE, d);
    check_value("mode", 8'h01, d);
    read_reg(ADDR_STATUS, d);
    check_value("status.tbs", 1, d[STAT_TBS_BIT]);
    check_value("status.tx", 0, d[STAT_TX_BIT]);

    // Bus timing writable only in reset mode
    write_reg(ADDR_BTR0, 8'(PRESC));
    write_reg(ADDR_BTR1, {1'b0, 3'(TSEG2), 4'(TSEG1)});
    write_reg(ADDR_MODE, 8'h00);
    write_reg(ADDR_BTR0, 8'h3f);
    write_reg(ADDR_BTR1, 8'h7f);
    read_reg(ADDR_BTR0, d);
    check_value("btr0", 8'(PRESC), d);
    read_reg(ADDR_BTR1, d);
    check_value("btr1", {1'b0, 3'(TSEG2), 4'(TSEG1)}, d);
    write_reg(ADDR_IRQ_EN, 8'(1 << IRQ_TX_BIT));

    for (int f = 0; f < NUM_FRAMES; f++)
    begin
      // Frame 0 is remote, frame 1 has an oversized DLC
      id  = 11'($urandom);
      rtr = (f == 0) ? 1'b1 : (f == 1) ? 1'b0 : ($urandom_range(0, 5) == 0);
      dlc = (f == 1) ? 4'd12 : 4'($urandom_range(0, 15));
      frame_bytes[0] = id[10:3];
      frame_bytes[1] = {id[2:0], rtr, dlc};
      for (int b = 2; b < FRAME_BYTES; b++)
        frame_bytes[b] = 8'($urandom);
      for (int b = 0; b < FRAME_BYTES; b++)
        write_buf(4'(b), frame_bytes[b]);
      build_expected();
      $display("frame %0d id=%h rtr=%0d dlc=%0d bits=%0d", f, id, rtr, dlc, exp_bits.size());
      write_reg(ADDR_CMD, 8'(1 << CMD_TX_REQ_BIT));
      check_frame(f % 2 == 1);

      // Still inside the last EOF bit, busy with the buffer locked
      read_reg(ADDR_STATUS, d);
      check_value("status.busy", 8'(1 << STAT_TX_BIT), d);
      wait_done();

      // Completion status and interrupt acknowledge
      read_reg(ADDR_STATUS, d);
      check_value("status", 8'((1 << STAT_TBS_BIT) | (1 << STAT_TCS_BIT)), d);
      check_value("irq_on", 0, irq_on);
      read_reg(ADDR_IRQ, d);
      check_value("irq", 8'(1 << IRQ_TX_BIT), d);
      check_value("irq_on", 1, irq_on);
    end

    // Request in reset mode is dropped
    write_reg(ADDR_MODE, 8'(1 << MODE_RESET_BIT));
    write_reg(ADDR_CMD, 8'(1 << CMD_TX_REQ_BIT));
    repeat (2 * BIT_CLKS)
    begin
      @(negedge clk_i);
      check_value("tx_o", 1, tx_o);
    end
    // A dropped request leaves TCS set and the buffer released
    read_reg(ADDR_STATUS, d);
    check_value("status", 8'((1 << STAT_TBS_BIT) | (1 << STAT_TCS_BIT)), d);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: can_tx_top.f
hw/can_cfg_pkg.sv
hw/can_frame_pkg.sv
hw/can_regs.sv
hw/can_tx_buffer.sv
hw/can_bit_timing.sv
hw/can_bit_tx.sv
hw/can_tx_top.sv
sim/can_tx_checker.sv
sim/can_tx_tb.sv

// File: Bender.yml
package:
  name: can_tx

sources:
  - files:
      - hw/can_cfg_pkg.sv
      - hw/can_frame_pkg.sv
      - hw/can_regs.sv
      - hw/can_tx_buffer.sv
      - hw/can_bit_timing.sv
      - hw/can_bit_tx.sv
      - hw/can_tx_top.sv
  - target: simulation
    files:
      - sim/can_tx_checker.sv
      - sim/can_tx_tb.sv
